//--- cacheSub.f
design/cachePkg.sv
design/cacheWay.sv
design/cacheCtrl.sv
design/cacheTop.sv
verif/tbClock.sv
verif/memModel.sv
verif/cache_checker.sv
verif/cacheTb.sv

//--- design/cacheCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module cacheCtrl (
  input  wire                     clk,
  input  wire                     rst_n,

  // pipeline side
  input  wire                     valid_i,
  input  wire cachePkg::addr_t    addr_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output cachePkg::data_t         rdData_o,

  // way read results
  input  wire                     hit0_i,
  input  wire                     hit1_i,
  input  wire cachePkg::line_t    line0_i,
  input  wire cachePkg::line_t    line1_i,

  // way read control, shared by both ways
  output logic                    rdEn_o,
  output cachePkg::index_t        rdIndex_o,
  output cachePkg::tag_t          cmpTag_o,

  // way fill control
  output logic                    fill0_o,
  output logic                    fill1_o,
  output cachePkg::index_t        fillIndex_o,
  output cachePkg::tag_t          fillTag_o,
  output cachePkg::line_t         fillLine_o,

  // memory read port
  output logic                    memRdReq_o,
  output cachePkg::addr_t         memAddr_o,
  input  wire                     memRdValid_i,
  input  wire                     memRdLast_i,
  input  wire cachePkg::data_t    memRdData_i
);

  cachePkg::ctrlState_t state;
  cachePkg::ctrlState_t nextState;

  // latched request and its fields
  cachePkg::addr_t   reqAddr;
  cachePkg::tag_t    reqTag;
  cachePkg::index_t  reqIndex;
  cachePkg::offset_t reqOffset;

  logic accept;
  logic anyHit;
  logic beatTaken;
  logic lastBeat;
  logic victim;

  // one bit per set, names the way to replace next
  logic [cachePkg::NumSets-1:0] lruBits;

  // refill beat assembly
  logic [$clog2(cachePkg::BeatsPerLine)-1:0] beatCnt;
  cachePkg::data_t beatBuf [cachePkg::BeatsPerLine];

  cachePkg::line_t hitLine;

  assign reqTag    = reqAddr[31:11];
  assign reqIndex  = reqAddr[10:5];
  assign reqOffset = reqAddr[4:0];

  // hit is only meaningful in the compare cycle
  assign anyHit   = (state == cachePkg::Compare) && (hit0_i || hit1_i);
  assign addrOk_o = (state == cachePkg::Idle) || anyHit;
  assign accept   = valid_i && addrOk_o;
  assign dataOk_o = anyHit;

  // new request reads the arrays, replay re-reads the held one
  assign rdEn_o    = accept || (state == cachePkg::Replay);
  assign rdIndex_o = (state == cachePkg::Replay) ? reqIndex : addr_i[10:5];
  assign cmpTag_o  = reqTag;

  assign memRdReq_o = (state == cachePkg::Refill);
  assign memAddr_o  = {reqAddr[31:5], 5'b0};

  assign beatTaken = memRdReq_o && memRdValid_i;
  assign lastBeat  = beatTaken && memRdLast_i;

  assign victim      = lruBits[reqIndex];
  assign fill0_o     = lastBeat && !victim;
  assign fill1_o     = lastBeat && victim;
  assign fillIndex_o = reqIndex;
  assign fillTag_o   = reqTag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cachePkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::Idle: begin
        if (valid_i) begin
          nextState = cachePkg::Compare;
        end
      end
      cachePkg::Compare: begin
        if (!anyHit) begin
          nextState = cachePkg::Refill;
        end else if (!valid_i) begin
          nextState = cachePkg::Idle;
        end
      end
      cachePkg::Refill: begin
        if (lastBeat) begin
          nextState = cachePkg::Replay;
        end
      end
      cachePkg::Replay: begin
        nextState = cachePkg::Compare;
      end
      default: begin
        nextState = cachePkg::Idle;
      end
    endcase
  end

  // address is held from acceptance through refill and replay
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // after a hit or a fill the set points at the other way
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lruBits <= '0;
    end else if (anyHit) begin
      lruBits[reqIndex] <= ~hit1_i;
    end else if (lastBeat) begin
      lruBits[reqIndex] <= ~victim;
    end
  end

  // beats arrive in ascending word order
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (lastBeat) begin
      beatCnt <= '0;
    end else if (beatTaken) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatTaken) begin
      beatBuf[beatCnt] <= memRdData_i;
    end
  end

  // the last beat goes straight into the fill line
  always_comb begin
    for (int b = 0; b < cachePkg::BeatsPerLine; b++) begin
      if (int'(beatCnt) == b) begin
        fillLine_o[b*64 +: 64] = memRdData_i;
      end else begin
        fillLine_o[b*64 +: 64] = beatBuf[b];
      end
    end
  end

  // word select from the hitting way
  assign hitLine = hit1_i ? line1_i : line0_i;

  always_comb begin
    case (reqOffset[4:3])
      2'd0:    rdData_o = hitLine[63:0];
      2'd1:    rdData_o = hitLine[127:64];
      2'd2:    rdData_o = hitLine[191:128];
      default: rdData_o = hitLine[255:192];
    endcase
  end

endmodule

`default_nettype wire

//--- design/cachePkg.sv
`default_nettype none

package cachePkg;

  // cache geometry
  localparam int NumSets      = 64;
  localparam int BeatsPerLine = 4;

  // byte address and payload widths
  typedef logic [31:0]  addr_t;
  typedef logic [63:0]  data_t;
  typedef logic [255:0] line_t;

  // address fields, tag 31:11, index 10:5, offset 4:0
  typedef logic [20:0]  tag_t;
  typedef logic [5:0]   index_t;
  typedef logic [4:0]   offset_t;

  // controller FSM
  typedef enum logic [1:0] {
    Idle,
    Compare,
    Refill,
    Replay
  } ctrlState_t;

endpackage

`default_nettype wire

//--- design/cacheTop.sv
`timescale 1ns/1ns
`default_nettype none

module cacheTop (
  input  wire                     clk,
  input  wire                     rst_n,

  // pipeline side
  input  wire                     valid_i,
  input  wire cachePkg::addr_t    addr_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output cachePkg::data_t         rdData_o,

  // memory read port
  output logic                    memRdReq_o,
  output cachePkg::addr_t         memAddr_o,
  input  wire                     memRdValid_i,
  input  wire                     memRdLast_i,
  input  wire cachePkg::data_t    memRdData_i
);

  // way results
  logic             hit0;
  logic             hit1;
  cachePkg::line_t  line0;
  cachePkg::line_t  line1;

  // shared read and fill buses
  logic             rdEn;
  cachePkg::index_t rdIndex;
  cachePkg::tag_t   cmpTag;
  logic             fill0;
  logic             fill1;
  cachePkg::index_t fillIndex;
  cachePkg::tag_t   fillTag;
  cachePkg::line_t  fillLine;

  cacheWay way0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdEn_i      (rdEn),
    .rdIndex_i   (rdIndex),
    .cmpTag_i    (cmpTag),
    .fillEn_i    (fill0),
    .fillIndex_i (fillIndex),
    .fillTag_i   (fillTag),
    .fillLine_i  (fillLine),
    .hit_o       (hit0),
    .rdLine_o    (line0)
  );

  cacheWay way1 (
    .clk         (clk),
    .rst_n       (rst_n),
    .rdEn_i      (rdEn),
    .rdIndex_i   (rdIndex),
    .cmpTag_i    (cmpTag),
    .fillEn_i    (fill1),
    .fillIndex_i (fillIndex),
    .fillTag_i   (fillTag),
    .fillLine_i  (fillLine),
    .hit_o       (hit1),
    .rdLine_o    (line1)
  );

  cacheCtrl ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid_i),
    .addr_i       (addr_i),
    .addrOk_o     (addrOk_o),
    .dataOk_o     (dataOk_o),
    .rdData_o     (rdData_o),
    .hit0_i       (hit0),
    .hit1_i       (hit1),
    .line0_i      (line0),
    .line1_i      (line1),
    .rdEn_o       (rdEn),
    .rdIndex_o    (rdIndex),
    .cmpTag_o     (cmpTag),
    .fill0_o      (fill0),
    .fill1_o      (fill1),
    .fillIndex_o  (fillIndex),
    .fillTag_o    (fillTag),
    .fillLine_o   (fillLine),
    .memRdReq_o   (memRdReq_o),
    .memAddr_o    (memAddr_o),
    .memRdValid_i (memRdValid_i),
    .memRdLast_i  (memRdLast_i),
    .memRdData_i  (memRdData_i)
  );

endmodule

`default_nettype wire

//--- design/cacheWay.sv
`timescale 1ns/1ns
`default_nettype none

module cacheWay (
  input  wire                     clk,
  input  wire                     rst_n,

  // read side, driven on acceptance or replay
  input  wire                     rdEn_i,
  input  wire cachePkg::index_t   rdIndex_i,
  input  wire cachePkg::tag_t     cmpTag_i,

  // fill side, one cycle at the end of a refill
  input  wire                     fillEn_i,
  input  wire cachePkg::index_t   fillIndex_i,
  input  wire cachePkg::tag_t     fillTag_i,
  input  wire cachePkg::line_t    fillLine_i,

  output logic                    hit_o,
  output cachePkg::line_t         rdLine_o
);

  // one valid bit per set
  logic [cachePkg::NumSets-1:0] validBits;

  // tag and data stores
  cachePkg::tag_t  tagArray  [cachePkg::NumSets];
  cachePkg::line_t lineArray [cachePkg::NumSets];

  // registered read of the addressed set
  logic            validQ;
  cachePkg::tag_t  tagQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
    end else if (fillEn_i) begin
      validBits[fillIndex_i] <= 1'b1;
    end
  end

  // arrays are written only by a refill
  always_ff @(posedge clk) begin
    if (fillEn_i) begin
      tagArray[fillIndex_i]  <= fillTag_i;
      lineArray[fillIndex_i] <= fillLine_i;
    end
  end

  // valid of the read entry, kept clean out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= 1'b0;
    end else if (rdEn_i) begin
      validQ <= validBits[rdIndex_i];
    end
  end

  // synchronous read of tag and line
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      tagQ     <= tagArray[rdIndex_i];
      rdLine_o <= lineArray[rdIndex_i];
    end
  end

  // compare against the tag of the pending request
  assign hit_o = validQ && (tagQ == cmpTag_i);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cacheSub.f --top-module cacheTb -o cacheSim

# assertion errors must not stop the run before the summary
./obj_dir/cacheSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
  echo "run.sh: pass"
  exit 0
fi
echo "run.sh: fail"
exit 1

//--- verif/cacheTb.sv
`timescale 1ns/1ns
`default_nettype none

module cacheTb;

  localparam int MissCycles  = 16;
  localparam int HitCycles   = 3;
  localparam int ResetCycles = 6;
  localparam int StreamLen   = 8;
  // 14 misses, 18 hits and 2 resets over all tests
  localparam int TestCycles  = 14 * MissCycles + 18 * HitCycles + 2 * ResetCycles;
  localparam int CycleLimit  = 2 * TestCycles;

  logic            clk;
  logic            rst_n;
  logic            resetReq;
  logic            valid;
  cachePkg::addr_t addr;
  logic            addrOk;
  logic            dataOk;
  cachePkg::data_t rdData;
  logic            memRdReq;
  cachePkg::addr_t memAddr;
  logic            memRdValid;
  logic            memRdLast;
  cachePkg::data_t memRdData;

  int dataErrors;
  int levelErrors;
  int protocolErrors;
  int assertFails;
  int cycleCount;

  cachePkg::addr_t streamAddrs [StreamLen];

  tbClock clockGen (.resetReq_i(resetReq), .clk(clk), .rst_n(rst_n));

  memModel mem (
    .clk          (clk),
    .memRdReq_i   (memRdReq),
    .memAddr_i    (memAddr),
    .memRdValid_o (memRdValid),
    .memRdLast_o  (memRdLast),
    .memRdData_o  (memRdData)
  );

  cacheTop i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid),
    .addr_i       (addr),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .memRdReq_o   (memRdReq),
    .memAddr_o    (memAddr),
    .memRdValid_i (memRdValid),
    .memRdLast_i  (memRdLast),
    .memRdData_i  (memRdData)
  );

  function automatic cachePkg::addr_t makeAddr(input cachePkg::tag_t t,
                                               input cachePkg::index_t s,
                                               input logic [1:0] w);
    return {t, s, w, 3'b000};
  endfunction

  // memory rule, inverted aligned address above the address
  function automatic cachePkg::data_t expWord(input cachePkg::addr_t a);
    cachePkg::addr_t aligned;
    aligned = {a[31:3], 3'b000};
    return {~aligned, aligned};
  endfunction

  task automatic checkData(input cachePkg::data_t expected, input cachePkg::data_t observed,
                           input string what);
    if (observed !== expected) begin
      dataErrors++;
      $display("FAILED at %0t ns: %s, expected %h got %h", $time, what, expected, observed);
    end
  endtask

  task automatic checkBit(input logic expected, input logic observed, input string what);
    if (observed !== expected) begin
      levelErrors++;
      $display("FAILED at %0t ns: %s, expected %b got %b", $time, what, expected, observed);
    end
  endtask

  task automatic checkIdleLevels();
    checkBit(1'b1, addrOk, "addrOk_o after reset");
    checkBit(1'b0, memRdReq, "memRdReq_o after reset");
    checkBit(1'b0, dataOk, "dataOk_o after reset");
  endtask

  task automatic applyReset();
    resetReq = 1'b1;
    @(posedge rst_n);
    resetReq = 1'b0;
    @(negedge clk);
  endtask

  // one request, called and left on a falling edge
  task automatic readAndCheck(input cachePkg::addr_t a, input logic expHit);
    int   waitCycles;
    logic sawReq;
    valid = 1'b1;
    addr  = a;
    waitCycles = 0;
    while (!addrOk && waitCycles < MissCycles) begin
      @(negedge clk);
      waitCycles++;
    end
    if (!addrOk) begin
      protocolErrors++;
      $display("request for address %h was never accepted", a);
      valid = 1'b0;
      return;
    end
    @(negedge clk);
    valid      = 1'b0;
    waitCycles = 1;
    sawReq     = 1'b0;
    while (!dataOk && waitCycles < MissCycles) begin
      if (memRdReq) begin
        sawReq = 1'b1;
      end
      @(negedge clk);
      waitCycles++;
    end
    if (!dataOk) begin
      protocolErrors++;
      $display("no dataOk_o pulse for address %h", a);
      return;
    end
    checkData(expWord(a), rdData, $sformatf("read of %h", a));
    checkBit(expHit, !sawReq, $sformatf("hit for %h", a));
    if (expHit) begin
      checkBit(1'b1, waitCycles == 1, $sformatf("one cycle hit for %h", a));
    end
    @(negedge clk);
    checkBit(1'b0, dataOk, "dataOk_o single pulse");
  endtask

  task automatic resetState();
    checkIdleLevels();
    readAndCheck(makeAddr(21'h000a5, 6'd3, 2'd1), 1'b0);
  endtask

  task automatic coldMissThenHits();
    readAndCheck(makeAddr(21'h01234, 6'd10, 2'd2), 1'b0);
    readAndCheck(makeAddr(21'h01234, 6'd10, 2'd0), 1'b1);
    readAndCheck(makeAddr(21'h01234, 6'd10, 2'd1), 1'b1);
    readAndCheck(makeAddr(21'h01234, 6'd10, 2'd3), 1'b1);
  endtask

  // valid held high, one word back per cycle
  task automatic streamingHits();
    for (int i = 0; i < StreamLen; i++) begin
      if (i < 5) begin
        streamAddrs[i] = makeAddr(21'h01234, 6'd10, 2'(3 - i));
      end else begin
        streamAddrs[i] = makeAddr(21'h000a5, 6'd3, 2'(i));
      end
    end
    for (int i = 0; i <= StreamLen; i++) begin
      if (i > 0) begin
        checkBit(1'b1, dataOk, $sformatf("stream dataOk_o for word %0d", i - 1));
        checkData(expWord(streamAddrs[i - 1]), rdData, $sformatf("stream word %0d", i - 1));
      end
      if (i < StreamLen) begin
        checkBit(1'b1, addrOk, "stream addrOk_o");
        valid = 1'b1;
        addr  = streamAddrs[i];
      end else begin
        valid = 1'b0;
      end
      @(negedge clk);
    end
    checkBit(1'b0, dataOk, "dataOk_o after stream end");
  endtask

  task automatic replacement();
    readAndCheck(makeAddr(21'h00100, 6'd20, 2'd0), 1'b0);
    readAndCheck(makeAddr(21'h00200, 6'd20, 2'd1), 1'b0);
    readAndCheck(makeAddr(21'h00100, 6'd20, 2'd2), 1'b1);
    // C takes the way of B
    readAndCheck(makeAddr(21'h00300, 6'd20, 2'd3), 1'b0);
    readAndCheck(makeAddr(21'h00100, 6'd20, 2'd1), 1'b1);
    readAndCheck(makeAddr(21'h00200, 6'd20, 2'd1), 1'b0);
    readAndCheck(makeAddr(21'h00100, 6'd20, 2'd3), 1'b1);
  endtask

  task automatic irregularRefill();
    for (int i = 0; i < 4; i++) begin
      readAndCheck(makeAddr(cachePkg::tag_t'(21'h00abc + i), cachePkg::index_t'(40 + i),
                            2'(3 - i)), 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      readAndCheck(makeAddr(cachePkg::tag_t'(21'h00abc + i), cachePkg::index_t'(40 + i),
                            2'(i)), 1'b1);
    end
    applyReset();
    checkIdleLevels();
    // every line is gone after reset
    for (int i = 0; i < 4; i++) begin
      readAndCheck(makeAddr(cachePkg::tag_t'(21'h00abc + i), cachePkg::index_t'(40 + i),
                            2'(3 - i)), 1'b0);
    end
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < CycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: tests still running after %0d cycles", CycleLimit);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    valid          = 1'b0;
    addr           = '0;
    resetReq       = 1'b0;
    dataErrors     = 0;
    levelErrors    = 0;
    protocolErrors = 0;
    @(posedge rst_n);
    @(negedge clk);
    resetState();
    coldMissThenHits();
    streamingHits();
    replacement();
    irregularRefill();
    assertFails = i_dut.i_checker.failCount;
    $display("errors: data %0d, level %0d, protocol %0d, assertion %0d",
             dataErrors, levelErrors, protocolErrors, assertFails);
    if (dataErrors + levelErrors + protocolErrors + assertFails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/cache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cacheChecker (
  input wire                  clk,
  input wire                  rst_n,
  input wire                  addrOk_i,
  input wire                  dataOk_i,
  input wire                  memRdReq_i,
  input wire cachePkg::addr_t memAddr_i
);

  int f0 = 0;
  int f1 = 0;
  int f2 = 0;
  int f3 = 0;
  int failCount;

  assign failCount = f0 + f1 + f2 + f3;

  // no response while a refill is pending
  assert property (@(posedge clk) disable iff (!rst_n) !(dataOk_i && memRdReq_i))
    else begin
      f0 = f0 + 1;
      $error("dataOk_o high during a memory read");
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      memRdReq_i && $past(memRdReq_i) |-> memAddr_i == $past(memAddr_i))
    else begin
      f1 = f1 + 1;
      $error("memAddr_o changed during a memory read");
    end

  // line aligned refill address
  assert property (@(posedge clk) disable iff (!rst_n) memRdReq_i |-> memAddr_i[4:0] == 5'd0)
    else begin
      f2 = f2 + 1;
      $error("memAddr_o not line aligned");
    end

  assert property (@(posedge clk) disable iff (!rst_n) memRdReq_i |-> !addrOk_i)
    else begin
      f3 = f3 + 1;
      $error("addrOk_o high during a memory read");
    end

endmodule

bind cacheTop cacheChecker i_checker (
  .clk        (clk),
  .rst_n      (rst_n),
  .addrOk_i   (addrOk_o),
  .dataOk_i   (dataOk_o),
  .memRdReq_i (memRdReq_o),
  .memAddr_i  (memAddr_o)
);

`default_nettype wire

//--- verif/memModel.sv
`timescale 1ns/1ns
`default_nettype none

module memModel (
  input  wire                  clk,
  input  wire                  memRdReq_i,
  input  wire cachePkg::addr_t memAddr_i,
  output logic                 memRdValid_o,
  output logic                 memRdLast_o,
  output cachePkg::data_t      memRdData_o
);

  localparam logic [31:0] LfsrSeed = 32'h5189748a;
  localparam logic [31:0] LfsrTaps = 32'h80200003;

  logic [31:0]     lfsr;
  int              beat;
  logic            gapTaken;
  logic            insertGap;
  cachePkg::addr_t beatAddr;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LfsrTaps;
    end
    return s >> 1;
  endfunction

  // inverted address above, address below
  function automatic cachePkg::data_t beatWord(input cachePkg::addr_t a);
    return {~a, a};
  endfunction

  initial begin
    lfsr         = LfsrSeed;
    beat         = 0;
    gapTaken     = 1'b0;
    insertGap    = 1'b0;
    beatAddr     = '0;
    memRdValid_o = 1'b0;
    memRdLast_o  = 1'b0;
    memRdData_o  = '0;
    forever begin
      @(negedge clk);
      memRdValid_o = 1'b0;
      memRdLast_o  = 1'b0;
      if (!memRdReq_i) begin
        beat     = 0;
        gapTaken = 1'b0;
      end else if (beat < cachePkg::BeatsPerLine) begin
        // at most one idle cycle between two beats
        insertGap = 1'b0;
        if (beat > 0 && !gapTaken) begin
          insertGap = lfsr[0];
          lfsr      = lfsrStep(lfsr);
        end
        if (insertGap) begin
          gapTaken = 1'b1;
        end else begin
          beatAddr     = memAddr_i + cachePkg::addr_t'(beat * 8);
          memRdValid_o = 1'b1;
          memRdLast_o  = (beat == cachePkg::BeatsPerLine - 1);
          memRdData_o  = beatWord(beatAddr);
          beat         = beat + 1;
          gapTaken     = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
  input  wire  resetReq_i,
  output logic clk,
  output logic rst_n
);

  localparam int HalfPeriod  = 10;
  localparam int ResetCycles = 3;

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // reset from time zero, then again on each request
  initial begin
    rst_n = 1'b0;
    forever begin
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(posedge resetReq_i);
      rst_n = 1'b0;
    end
  end

endmodule

`default_nettype wire
